//--- csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int xlen = 32;
    localparam int int_code_width = 8;

    typedef logic [11:0] csr_addr_t;
    typedef logic [xlen-1:0] word_t;

    // machine csr addresses
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_MIP       = 12'h344;
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;

    // mxl = 1 (32 bit), extension I
    localparam word_t MISA_RESET = 32'h4000_0100;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // interrupt numbers, also the mip/mie bit positions
    localparam int IRQ_MEI = 11;
    localparam int IRQ_MSI = 3;
    localparam int IRQ_MTI = 7;

    typedef enum logic [1:0] {
        IRQ_NONE   = 2'd0,
        IRQ_PERIPH = 2'd1,
        IRQ_SOFT   = 2'd2,
        IRQ_TIMER  = 2'd3
    } irq_sel_e;

    // mtvec base, plus 4*cause for interrupts in vectored mode
    function automatic word_t trap_target(
        input word_t mtvec,
        input logic  is_int,
        input word_t cause
    );
        word_t base;
        base = {mtvec[xlen-1:2], 2'b00};
        if (mtvec[0] && is_int) begin
            return base + (cause << 2);
        end
        return base;
    endfunction

endpackage

`default_nettype wire

//--- csr_irq_if.sv
`timescale 1ns/1ps
`default_nettype none

interface csr_irq_if;
    import csr_pkg::*;

    logic [2:0] mip_bits;    // {mei, mti, msi}
    logic       int_pending;
    irq_sel_e   int_sel;

    word_t      mie;
    logic       global_en;   // mstatus.MIE
    logic       in_service;

    modport arbiter (
        output mip_bits,
        output int_pending,
        output int_sel,
        input  mie,
        input  global_en,
        input  in_service
    );

    modport csr (
        input  mip_bits,
        input  int_pending,
        input  int_sel,
        output mie,
        output global_en,
        output in_service
    );

endinterface

`default_nettype wire

//--- machine_timer.sv
`timescale 1ns/1ps
`default_nettype none

module machine_timer #(
    parameter int unsigned TIMER_DIV = 4
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire csr_pkg::word_t cmp_low,
    input  wire csr_pkg::word_t cmp_high,
    input  wire logic          set_cmp_low,
    input  wire logic          set_cmp_high,
    output csr_pkg::word_t     mtime_low,
    output csr_pkg::word_t     mtime_high,
    output logic               mtip
);
    import csr_pkg::*;

    localparam int PRE_W = $clog2(TIMER_DIV + 1);
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TIMER_DIV - 1);

    logic [PRE_W-1:0]  prescale;
    logic              tick;
    logic [2*xlen-1:0] mtime;
    logic [2*xlen-1:0] mtimecmp;

    assign tick = (prescale == PRE_LAST);   // one pulse per TIMER_DIV clocks

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            prescale <= '0;
            mtime    <= '0;
        end else begin
            if (tick) begin
                prescale <= '0;
                mtime    <= mtime + 1'b1;
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

    // low half has priority when both strobes arrive together
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mtimecmp <= '1;   // all ones keeps mtip low
        end else if (set_cmp_low) begin
            mtimecmp[xlen-1:0] <= cmp_low;
        end else if (set_cmp_high) begin
            mtimecmp[2*xlen-1:xlen] <= cmp_high;
        end
    end

    assign mtip       = (mtime >= mtimecmp);
    assign mtime_low  = mtime[xlen-1:0];
    assign mtime_high = mtime[2*xlen-1:xlen];

    // prescaler wraps before it passes the divider
    a_prescale_range: assert property (
        @(posedge clk) disable iff (!rst)
        prescale <= PRE_LAST
    ) else $error("prescaler out of range: %0d", prescale);

endmodule

`default_nettype wire

//--- irq_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module irq_arbiter (
    input  wire logic [csr_pkg::int_code_width-1:0] peripheral_int_code,
    input  wire logic [csr_pkg::int_code_width-1:0] soft_int_code,
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               mtip,
    output logic [csr_pkg::int_code_width-1:0]      cur_int_code,
    csr_irq_if.arbiter                              irq
);
    import csr_pkg::*;

    logic periph_pend;
    logic soft_pend;
    logic periph_act;
    logic soft_act;
    logic timer_act;

    assign periph_pend = |peripheral_int_code;
    assign soft_pend   = |soft_int_code;

    assign irq.mip_bits = {periph_pend, mtip, soft_pend};

    // pending and enabled in mie
    assign periph_act = irq.mip_bits[2] & irq.mie[IRQ_MEI];
    assign soft_act   = irq.mip_bits[0] & irq.mie[IRQ_MSI];
    assign timer_act  = irq.mip_bits[1] & irq.mie[IRQ_MTI];

    // fixed priority: peripheral, software, timer
    always_comb begin
        if (periph_act) begin
            irq.int_sel = IRQ_PERIPH;
        end else if (soft_act) begin
            irq.int_sel = IRQ_SOFT;
        end else if (timer_act) begin
            irq.int_sel = IRQ_TIMER;
        end else begin
            irq.int_sel = IRQ_NONE;
        end
    end

    assign irq.int_pending = (irq.int_sel != IRQ_NONE) & irq.global_en & ~irq.in_service;

    // remember the latest nonzero source code
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cur_int_code <= '0;
        end else if (periph_pend) begin
            cur_int_code <= peripheral_int_code;
        end else if (soft_pend) begin
            cur_int_code <= soft_int_code;
        end
    end

    // a request names a source that is really pending and enabled
    a_pending_has_source: assert property (
        @(posedge clk) disable iff (!rst)
        irq.int_pending |->
            (irq.int_sel == IRQ_PERIPH && peripheral_int_code != '0 && irq.mie[IRQ_MEI])
            || (irq.int_sel == IRQ_SOFT && soft_int_code != '0 && irq.mie[IRQ_MSI])
            || (irq.int_sel == IRQ_TIMER && mtip && irq.mie[IRQ_MTI])
    ) else $error("int_pending without a pending enabled source");

endmodule

`default_nettype wire

//--- csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire csr_pkg::word_t    exp_pc,
    input  wire csr_pkg::word_t    exp_pc_next,
    input  wire csr_pkg::word_t    exp_val,
    input  wire csr_pkg::word_t    exception_code,
    input  wire logic              exception_en,
    input  wire logic              mret_en,
    input  wire logic              int_jmp_ready,
    input  wire csr_pkg::csr_addr_t csr_read_addr,
    input  wire csr_pkg::csr_addr_t csrw_addr,
    input  wire csr_pkg::word_t    w_data,
    input  wire logic              write_en,
    output logic                   jmp_en,
    output csr_pkg::word_t         jmp_pc,
    output csr_pkg::word_t         csr_out,
    csr_irq_if.csr                 irq
);
    import csr_pkg::*;

    word_t mstatus;
    word_t mie;
    word_t mtvec;
    word_t mscratch;
    word_t mepc;
    word_t mcause;
    word_t mtval;
    word_t mip;
    logic  in_service;   // set on interrupt entry, cleared by mret

    logic  int_take;
    word_t int_cause;    // cause number of the selected source

    assign irq.mie        = mie;
    assign irq.global_en  = mstatus[MSTATUS_MIE_BIT];
    assign irq.in_service = in_service;

    assign int_take = int_jmp_ready & irq.int_pending;

    // mip is a view of the live sources
    always_comb begin
        mip          = '0;
        mip[IRQ_MSI] = irq.mip_bits[0];
        mip[IRQ_MTI] = irq.mip_bits[1];
        mip[IRQ_MEI] = irq.mip_bits[2];
    end

    always_comb begin
        case (irq.int_sel)
            IRQ_PERIPH: int_cause = word_t'(IRQ_MEI);
            IRQ_SOFT:   int_cause = word_t'(IRQ_MSI);
            IRQ_TIMER:  int_cause = word_t'(IRQ_MTI);
            default:    int_cause = '0;
        endcase
    end

    always_comb begin
        case (csr_read_addr)
            CSR_MSTATUS:  csr_out = mstatus;
            CSR_MISA:     csr_out = MISA_RESET;
            CSR_MIE:      csr_out = mie;
            CSR_MTVEC:    csr_out = mtvec;
            CSR_MSCRATCH: csr_out = mscratch;
            CSR_MEPC:     csr_out = mepc;
            CSR_MCAUSE:   csr_out = mcause;
            CSR_MTVAL:    csr_out = mtval;
            CSR_MIP:      csr_out = mip;
            CSR_MVENDORID,
            CSR_MARCHID,
            CSR_MIMPID,
            CSR_MHARTID:  csr_out = '0;   // id registers read zero
            default:      csr_out = '0;
        endcase
    end

    // mret, then exception, then interrupt ack, then csr write
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mstatus    <= '0;
            mie        <= '0;
            mtvec      <= '0;
            mscratch   <= '0;
            mepc       <= '0;
            mcause     <= '0;
            mtval      <= '0;
            in_service <= 1'b0;
            jmp_en     <= 1'b0;
        end else begin
            jmp_en <= 1'b0;
            if (mret_en) begin
                jmp_en                     <= 1'b1;
                mstatus[MSTATUS_MIE_BIT]  <= mstatus[MSTATUS_MPIE_BIT];
                mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
                in_service                 <= 1'b0;
            end else if (exception_en) begin
                jmp_en                     <= 1'b1;
                mcause                     <= exception_code;
                mepc                       <= exp_pc;
                mtval                      <= exp_val;
                mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
                mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
            end else if (int_take) begin
                jmp_en                     <= 1'b1;
                mcause                     <= {1'b1, int_cause[xlen-2:0]};
                mepc                       <= exp_pc_next;   // resume after current
                mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
                mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
                in_service                 <= 1'b1;
            end else if (write_en) begin
                case (csrw_addr)
                    CSR_MSTATUS:  mstatus  <= w_data;
                    CSR_MIE:      mie      <= w_data;
                    CSR_MTVEC:    mtvec    <= w_data;
                    CSR_MSCRATCH: mscratch <= w_data;
                    CSR_MEPC:     mepc     <= w_data;
                    CSR_MCAUSE:   mcause   <= w_data;
                    CSR_MTVAL:    mtval    <= w_data;
                    default: ;   // misa, mip, ids are read only
                endcase
            end
        end
    end

    // jump target, valid only while jmp_en is high
    always_ff @(posedge clk) begin
        if (mret_en) begin
            jmp_pc <= mepc;
        end else if (exception_en) begin
            jmp_pc <= trap_target(mtvec, 1'b0, '0);   // exceptions never vector
        end else if (int_take) begin
            jmp_pc <= trap_target(mtvec, 1'b1, int_cause);
        end
    end

    a_jmp_single_pulse: assert property (
        @(posedge clk) disable iff (!rst)
        jmp_en |=> !jmp_en
    ) else $error("jmp_en high for two cycles");

endmodule

`default_nettype wire

//--- csr_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module csr_subsystem #(
    parameter int unsigned TIMER_DIV = 4
) (
    input  wire logic                               clk,
    input  wire logic                               rst,

    // trap interface from the pipeline
    input  wire csr_pkg::word_t                     exp_pc,
    input  wire csr_pkg::word_t                     exp_pc_next,
    input  wire csr_pkg::word_t                     exp_val,
    input  wire csr_pkg::word_t                     exception_code,
    input  wire logic                               exception_en,
    input  wire logic                               int_jmp_ready,
    input  wire logic                               mret_en,
    output logic                                    int_en,
    output logic                                    jmp_en,
    output csr_pkg::word_t                          jmp_pc,

    // interrupt sources
    input  wire logic [csr_pkg::int_code_width-1:0] peripheral_int_code,
    input  wire logic [csr_pkg::int_code_width-1:0] soft_int_code,
    output logic [csr_pkg::int_code_width-1:0]      cur_int_code,

    // machine timer
    input  wire csr_pkg::word_t                     mtimecmp_low,
    input  wire csr_pkg::word_t                     mtimecmp_high,
    input  wire logic                               set_mtimecmp_low,
    input  wire logic                               set_mtimecmp_high,
    output csr_pkg::word_t                          mtime_low,
    output csr_pkg::word_t                          mtime_high,

    // csr access
    input  wire csr_pkg::csr_addr_t                 csr_read_addr,
    input  wire csr_pkg::csr_addr_t                 csrw_addr,
    input  wire csr_pkg::word_t                     w_data,
    input  wire logic                               write_en,
    output csr_pkg::word_t                          csr_out
);

    logic mtip;

    csr_irq_if irq_bus ();

    machine_timer #(
        .TIMER_DIV    (TIMER_DIV)
    ) u_timer (
        .clk          (clk),
        .rst          (rst),
        .cmp_low      (mtimecmp_low),
        .cmp_high     (mtimecmp_high),
        .set_cmp_low  (set_mtimecmp_low),
        .set_cmp_high (set_mtimecmp_high),
        .mtime_low    (mtime_low),
        .mtime_high   (mtime_high),
        .mtip         (mtip)
    );

    irq_arbiter u_arbiter (
        .peripheral_int_code (peripheral_int_code),
        .soft_int_code       (soft_int_code),
        .clk                 (clk),
        .rst                 (rst),
        .mtip                (mtip),
        .cur_int_code        (cur_int_code),
        .irq                 (irq_bus.arbiter)
    );

    csr_file u_csr (
        .clk            (clk),
        .rst            (rst),
        .exp_pc         (exp_pc),
        .exp_pc_next    (exp_pc_next),
        .exp_val        (exp_val),
        .exception_code (exception_code),
        .exception_en   (exception_en),
        .mret_en        (mret_en),
        .int_jmp_ready  (int_jmp_ready),
        .csr_read_addr  (csr_read_addr),
        .csrw_addr      (csrw_addr),
        .w_data         (w_data),
        .write_en       (write_en),
        .jmp_en         (jmp_en),
        .jmp_pc         (jmp_pc),
        .csr_out        (csr_out),
        .irq            (irq_bus.csr)
    );

    assign int_en = irq_bus.int_pending;   // held until acknowledged

endmodule

`default_nettype wire

//--- tb_csr_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_subsystem;
    import csr_pkg::*;

    localparam int TIMER_DIV = 4;

    typedef enum logic [3:0] {
        OP_WR, OP_RD, OP_RAND, OP_EXC, OP_MRET, OP_SRC,
        OP_INTCHK, OP_WAITINT, OP_ACK, OP_MTIME, OP_SETCMP
    } op_e;

    typedef struct packed {
        op_e       kind;
        csr_addr_t addr;
        word_t     data;
        word_t     exp;
    } step_t;

    logic clk;
    logic rst;
    logic exception_en, mret_en, int_jmp_ready, write_en;
    logic set_mtimecmp_low, set_mtimecmp_high;
    logic int_en, jmp_en;
    word_t exp_pc, exp_pc_next, exp_val, exception_code;
    word_t mtimecmp_low, mtimecmp_high, mtime_low, mtime_high;
    word_t w_data, jmp_pc, csr_out;
    csr_addr_t csr_read_addr, csrw_addr;
    logic [int_code_width-1:0] peripheral_int_code, soft_int_code, cur_int_code;

    word_t m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
    logic [int_code_width-1:0] m_periph, m_soft;   // source codes as driven
    logic [2*xlen-1:0] last_mtime;
    word_t rng;
    step_t steps[$];
    int cycles = 0;
    int limit = 0;

    csr_subsystem #(.TIMER_DIV(TIMER_DIV)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the table did not finish within %0d cycles", limit);
            stop_on_failure();
        end
    end

    task automatic stop_on_failure();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_equal(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    function automatic word_t xorshift32(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t model_read(input csr_addr_t addr);
        word_t mip;
        mip          = '0;
        mip[IRQ_MEI] = |m_periph;
        mip[IRQ_MSI] = |m_soft;   // mtip stays low outside the timer steps
        case (addr)
            CSR_MSTATUS:  return m_mstatus;
            CSR_MISA:     return MISA_RESET;
            CSR_MIE:      return m_mie;
            CSR_MTVEC:    return m_mtvec;
            CSR_MSCRATCH: return m_mscratch;
            CSR_MEPC:     return m_mepc;
            CSR_MCAUSE:   return m_mcause;
            CSR_MTVAL:    return m_mtval;
            CSR_MIP:      return mip;
            default:      return '0;   // ids and unmapped
        endcase
    endfunction

    function automatic void model_write(input csr_addr_t addr, input word_t data);
        case (addr)
            CSR_MSTATUS:  m_mstatus  = data;
            CSR_MIE:      m_mie      = data;
            CSR_MTVEC:    m_mtvec    = data;
            CSR_MSCRATCH: m_mscratch = data;
            CSR_MEPC:     m_mepc     = data;
            CSR_MCAUSE:   m_mcause   = data;
            CSR_MTVAL:    m_mtval    = data;
            default: ;   // misa, mip and ids keep their value
        endcase
    endfunction

    task automatic write_csr(input csr_addr_t addr, input word_t data);
        @(posedge clk);
        csrw_addr <= addr;
        w_data    <= data;
        write_en  <= 1'b1;
        @(posedge clk);
        write_en  <= 1'b0;
        model_write(addr, data);
    endtask

    task automatic read_csr(input csr_addr_t addr);
        @(posedge clk);
        csr_read_addr <= addr;
        @(negedge clk);
        check_equal($sformatf("csr_out[%h]", addr), csr_out, model_read(addr));
    endtask

    // one strobe cycle, then the jump pulse shows after the edge
    task automatic strobe_and_check_jump(input int which, input word_t target);
        @(posedge clk);
        case (which)
            0:       exception_en  <= 1'b1;
            1:       mret_en       <= 1'b1;
            default: int_jmp_ready <= 1'b1;
        endcase
        @(posedge clk);
        exception_en  <= 1'b0;
        mret_en       <= 1'b0;
        int_jmp_ready <= 1'b0;
        @(negedge clk);
        check_equal("jmp_en", jmp_en, 1);
        check_equal("jmp_pc", jmp_pc, target);
    endtask

    task automatic run_step(input step_t s);
        logic [2*xlen-1:0] now;
        int waited;
        case (s.kind)
            OP_WR: begin
                write_csr(s.addr, s.data);
                read_csr(s.addr);
            end
            OP_RD: read_csr(s.addr);
            OP_RAND: begin
                rng = xorshift32(rng);
                write_csr(CSR_MSCRATCH, rng);
                read_csr(CSR_MSCRATCH);
            end
            OP_EXC: begin
                @(posedge clk);
                exp_pc         <= s.data;
                exp_val        <= ~s.data;
                exception_code <= s.exp;
                // exceptions go to the mtvec base in either mode
                strobe_and_check_jump(0, {m_mtvec[xlen-1:2], 2'b00});
                m_mepc   = s.data;
                m_mcause = s.exp;
                m_mtval  = ~s.data;
                m_mstatus[MSTATUS_MPIE_BIT] = m_mstatus[MSTATUS_MIE_BIT];
                m_mstatus[MSTATUS_MIE_BIT]  = 1'b0;
            end
            OP_MRET: begin
                strobe_and_check_jump(1, m_mepc);
                m_mstatus[MSTATUS_MIE_BIT]  = m_mstatus[MSTATUS_MPIE_BIT];
                m_mstatus[MSTATUS_MPIE_BIT] = 1'b1;
            end
            OP_ACK: begin
                @(posedge clk);
                exp_pc_next <= s.data;
                // vectored mode adds four bytes per cause number
                strobe_and_check_jump(2, {m_mtvec[xlen-1:2], 2'b00}
                                         + (m_mtvec[0] ? s.exp * 4 : 32'd0));
                m_mcause = 32'h8000_0000 | s.exp;   // interrupt flag plus cause
                m_mepc   = s.data;
                m_mstatus[MSTATUS_MPIE_BIT] = m_mstatus[MSTATUS_MIE_BIT];
                m_mstatus[MSTATUS_MIE_BIT]  = 1'b0;
            end
            OP_SRC: begin
                @(posedge clk);
                m_periph = s.data[int_code_width-1:0];
                m_soft   = s.data[2*int_code_width-1:int_code_width];
                peripheral_int_code <= m_periph;
                soft_int_code       <= m_soft;
                @(negedge clk);
            end
            OP_INTCHK: begin
                @(negedge clk);
                check_equal("int_en", int_en, s.data);
            end
            OP_WAITINT: begin
                waited = 0;
                @(negedge clk);
                while (!int_en) begin
                    assert (waited < (s.data + 2) * TIMER_DIV) else begin
                        $display("int_en did not rise within %0d cycles", waited);
                        stop_on_failure();
                    end
                    waited++;
                    @(negedge clk);
                end
                check_equal("cur_int_code", cur_int_code, s.exp);
            end
            OP_MTIME: begin
                repeat (s.data) @(posedge clk);
                @(negedge clk);
                now = {mtime_high, mtime_low};
                assert (now > last_mtime) else begin
                    $display("[ERROR] mtime: 0x%h not above 0x%h", now, last_mtime);
                    stop_on_failure();
                end
                last_mtime = now;
            end
            OP_SETCMP: begin
                @(negedge clk);
                now = {mtime_high, mtime_low} + s.data;
                @(posedge clk);
                mtimecmp_high     <= now[2*xlen-1:xlen];   // high first, low stays all ones
                set_mtimecmp_high <= 1'b1;
                @(posedge clk);
                set_mtimecmp_high <= 1'b0;
                mtimecmp_low      <= now[xlen-1:0];
                set_mtimecmp_low  <= 1'b1;
                @(posedge clk);
                set_mtimecmp_low  <= 1'b0;
            end
            default: ;
        endcase
    endtask

    function automatic void add_step(input op_e kind, input csr_addr_t addr,
                                     input word_t data, input word_t exp);
        step_t s;
        s.kind = kind;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        add_step(OP_WR, CSR_MSTATUS, 32'h0000_1880, 0);
        add_step(OP_WR, CSR_MIE, 32'h0000_0888, 0);
        add_step(OP_WR, CSR_MTVEC, 32'h1000_0100, 0);
        add_step(OP_WR, CSR_MEPC, 32'h0000_2468, 0);
        add_step(OP_WR, CSR_MCAUSE, 32'h0000_000D, 0);
        add_step(OP_WR, CSR_MTVAL, 32'hDEAD_BEEF, 0);
        add_step(OP_RAND, CSR_MSCRATCH, 0, 0);
        add_step(OP_RAND, CSR_MSCRATCH, 0, 0);
        add_step(OP_RAND, CSR_MSCRATCH, 0, 0);
        add_step(OP_RD, CSR_MISA, 0, 0);
        add_step(OP_WR, CSR_MISA, 32'hFFFF_FFFF, 0);
        add_step(OP_SRC, 0, 32'h0000_0021, 0);
        add_step(OP_WR, CSR_MIP, 32'hFFFF_FFFF, 0);
        add_step(OP_SRC, 0, 32'h0000_0000, 0);
        add_step(OP_WR, CSR_MHARTID, 32'h1234_5678, 0);
        add_step(OP_WR, CSR_MVENDORID, 32'hA5A5_A5A5, 0);
        add_step(OP_RD, 12'h7C0, 0, 0);
        // exception and mret
        add_step(OP_WR, CSR_MSTATUS, 32'h0000_0008, 0);
        add_step(OP_WR, CSR_MTVEC, 32'h2000_0001, 0);
        add_step(OP_EXC, 0, 32'h0000_0400, 32'd2);
        add_step(OP_RD, CSR_MEPC, 0, 0);
        add_step(OP_RD, CSR_MCAUSE, 0, 0);
        add_step(OP_RD, CSR_MTVAL, 0, 0);
        add_step(OP_RD, CSR_MSTATUS, 0, 0);
        add_step(OP_MRET, 0, 0, 0);
        add_step(OP_RD, CSR_MSTATUS, 0, 0);
        // peripheral interrupt, vectored
        add_step(OP_WR, CSR_MIE, 32'h0000_0800, 0);
        add_step(OP_INTCHK, 0, 0, 0);
        add_step(OP_SRC, 0, 32'h0000_0025, 0);
        add_step(OP_WAITINT, 0, 0, 32'h25);
        add_step(OP_ACK, 0, 32'h0000_0504, IRQ_MEI);
        add_step(OP_RD, CSR_MCAUSE, 0, 0);
        add_step(OP_INTCHK, 0, 0, 0);
        add_step(OP_MRET, 0, 0, 0);
        // peripheral wins over software
        add_step(OP_WR, CSR_MIE, 32'h0000_0808, 0);
        add_step(OP_SRC, 0, 32'h0000_132A, 0);
        add_step(OP_WAITINT, 0, 0, 32'h2A);
        add_step(OP_ACK, 0, 32'h0000_0600, IRQ_MEI);
        add_step(OP_SRC, 0, 32'h0000_1300, 0);
        add_step(OP_INTCHK, 0, 0, 0);
        add_step(OP_MRET, 0, 0, 0);
        add_step(OP_WAITINT, 0, 0, 32'h13);
        add_step(OP_ACK, 0, 32'h0000_0700, IRQ_MSI);
        add_step(OP_RD, CSR_MCAUSE, 0, 0);
        add_step(OP_MRET, 0, 0, 0);
        // machine timer
        add_step(OP_WR, CSR_MIE, 32'h0000_0080, 0);
        add_step(OP_MTIME, 0, 0, 0);
        add_step(OP_MTIME, 0, 2 * TIMER_DIV, 0);
        add_step(OP_SETCMP, 0, 6, 0);
        add_step(OP_INTCHK, 0, 0, 0);
        add_step(OP_WAITINT, 0, 6, 32'h13);   // code register holds the last source
        add_step(OP_ACK, 0, 32'h0000_0800, IRQ_MTI);
        add_step(OP_RD, CSR_MCAUSE, 0, 0);
    endfunction

    initial begin
        rst                 = 1'b0;
        exp_pc              = '0;
        exp_pc_next         = '0;
        exp_val             = '0;
        exception_code      = '0;
        exception_en        = 1'b0;
        mret_en             = 1'b0;
        int_jmp_ready       = 1'b0;
        write_en            = 1'b0;
        w_data              = '0;
        csr_read_addr       = '0;
        csrw_addr           = '0;
        set_mtimecmp_low    = 1'b0;
        set_mtimecmp_high   = 1'b0;
        mtimecmp_low        = '0;
        mtimecmp_high       = '0;
        peripheral_int_code = '0;
        soft_int_code       = '0;
        m_mstatus  = '0;
        m_mie      = '0;
        m_mtvec    = '0;
        m_mscratch = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        m_mtval    = '0;
        m_periph   = '0;
        m_soft     = '0;
        last_mtime = '0;
        rng        = 32'd95;
        build_table();
        limit = 2 * steps.size() * 16 + 64 * TIMER_DIV;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
csr_pkg.sv
csr_irq_if.sv
machine_timer.sv
irq_arbiter.sv
csr_file.sv
csr_subsystem.sv
tb_csr_subsystem.sv

//--- Bender.yml
package:
  name: csr_subsystem

sources:
  - csr_pkg.sv
  - csr_irq_if.sv
  - machine_timer.sv
  - irq_arbiter.sv
  - csr_file.sv
  - csr_subsystem.sv
  - target: test
    files:
      - tb_csr_subsystem.sv
